//--- hdl/csr_pkg.sv
// CSR package
// shared widths, operation and privilege encodings, CSR addresses,
// WARL write masks and trap cause codes for the machine-mode CSR file
package csr_pkg;

    // data path width
    localparam int XLEN = 64;

    // operation requested by the issue stage
    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_READ,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR,
        CSR_MRET
    } csr_op_e;

    // only user and machine mode exist
    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_lvl_e;

    // ------------------------------------------------------------------
    // implemented CSR addresses
    // ------------------------------------------------------------------
    typedef enum logic [11:0] {
        MSTATUS  = 12'h300,
        MIE      = 12'h304,
        MTVEC    = 12'h305,
        MSCRATCH = 12'h340,
        MEPC     = 12'h341,
        MCAUSE   = 12'h342,
        MTVAL    = 12'h343,
        MIP      = 12'h344,
        MCYCLE   = 12'hB00,
        MINSTRET = 12'hB02,
        CYCLE    = 12'hC00,
        INSTRET  = 12'hC02
    } csr_addr_e;

    // msie, mtie and meie are the only enables
    localparam logic [XLEN-1:0] MIE_MASK  = 64'h888;
    // msip and mtip are software writable, meip comes from the irq line
    localparam logic [XLEN-1:0] MIP_WMASK = 64'h088;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // interrupt bit indices in mie / mip
    localparam int IRQ_M_SW    = 3;
    localparam int IRQ_M_TIMER = 7;
    localparam int IRQ_M_EXT   = 11;

    // trap causes
    localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 64'd2;
    localparam logic [XLEN-1:0] INTERRUPT_FLAG      = 64'h8000_0000_0000_0000;

endpackage

//--- hdl/csr_wr_if.sv
// CSR write interface
// carries the qualified write strobe, address, data and the mret strobe
// from access control to the register blocks
interface csr_wr_if;
    import csr_pkg::*;

    // one-cycle strobe, only for a legal write
    logic            we;
    logic [11:0]     addr;
    logic [XLEN-1:0] wdata;
    // return from trap
    logic            mret;

    modport source (output we, addr, wdata, mret);
    modport sink   (input  we, addr, wdata, mret);

endinterface

//--- hdl/csr_access_ctrl.sv
// CSR access control
// decodes the CSR operation, forms set/clear write data from the current
// value and flags unknown, under-privileged or read-only accesses
module csr_access_ctrl (
    input  csr_pkg::csr_op_e         csr_op_i,
    input  logic [11:0]              csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
    input  csr_pkg::priv_lvl_e       priv_lvl_i,
    input  logic [csr_pkg::XLEN-1:0] rdata_i,
    input  logic                     hit_i,
    output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
    output logic                     illegal_o,
    csr_wr_if.source                 wr
);
    import csr_pkg::*;

    logic            access;
    logic            write;
    logic            priv_low;
    logic            read_only;
    logic [XLEN-1:0] wdata;

    // ------------------------------------------------------------------
    // operation decode
    // ------------------------------------------------------------------
    always_comb begin
        access = 1'b1;
        write  = 1'b1;
        wdata  = csr_wdata_i;
        case (csr_op_i)
            CSR_READ:  write = 1'b0;
            CSR_WRITE: wdata = csr_wdata_i;
            // set and clear are read-modify-write on the current value
            CSR_SET:   wdata = csr_wdata_i | rdata_i;
            CSR_CLEAR: wdata = ~csr_wdata_i & rdata_i;
            default: begin
                // none and mret touch no register through the port
                access = 1'b0;
                write  = 1'b0;
            end
        endcase
    end

    // privilege field in addr[9:8] must not exceed the current level
    assign priv_low  = csr_addr_i[9:8] > priv_lvl_i;
    // addr[11:10] == 2'b11 marks a read-only CSR
    assign read_only = write && (&csr_addr_i[11:10]);
    assign illegal_o = access && (!hit_i || priv_low || read_only);

    // an illegal access returns zero and writes nothing
    assign csr_rdata_o = (access && !illegal_o) ? rdata_i : '0;

    assign wr.we    = write && !illegal_o;
    assign wr.addr  = csr_addr_i;
    assign wr.wdata = wdata;
    assign wr.mret  = (csr_op_i == CSR_MRET);

endmodule

//--- hdl/csr_read_mux.sv
// CSR read multiplexer
// selects the addressed register value and reports whether the address
// belongs to an implemented CSR
module csr_read_mux (
    input  logic [11:0]              addr_i,
    input  logic [csr_pkg::XLEN-1:0] mstatus_i,
    input  logic [csr_pkg::XLEN-1:0] mie_i,
    input  logic [csr_pkg::XLEN-1:0] mip_i,
    input  logic [csr_pkg::XLEN-1:0] mtvec_i,
    input  logic [csr_pkg::XLEN-1:0] mscratch_i,
    input  logic [csr_pkg::XLEN-1:0] mepc_i,
    input  logic [csr_pkg::XLEN-1:0] mcause_i,
    input  logic [csr_pkg::XLEN-1:0] mtval_i,
    input  logic [csr_pkg::XLEN-1:0] cycle_i,
    input  logic [csr_pkg::XLEN-1:0] instret_i,
    output logic [csr_pkg::XLEN-1:0] rdata_o,
    output logic                     hit_o
);
    import csr_pkg::*;

    always_comb begin
        rdata_o = '0;
        hit_o   = 1'b1;
        case (csr_addr_e'(addr_i))
            MSTATUS:  rdata_o = mstatus_i;
            MIE:      rdata_o = mie_i;
            MIP:      rdata_o = mip_i;
            MTVEC:    rdata_o = mtvec_i;
            MSCRATCH: rdata_o = mscratch_i;
            MEPC:     rdata_o = mepc_i;
            MCAUSE:   rdata_o = mcause_i;
            MTVAL:    rdata_o = mtval_i;
            // machine and user views of the counters share one value
            MCYCLE,
            CYCLE:    rdata_o = cycle_i;
            MINSTRET,
            INSTRET:  rdata_o = instret_i;
            // unknown address
            default:  hit_o = 1'b0;
        endcase
    end

endmodule

//--- hdl/trap_ctrl.sv
// trap control
// holds the privilege level, mstatus, mepc, mcause and mtval; handles
// trap entry from the commit stage, mret and the flush on mstatus writes
module trap_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    csr_wr_if.sink                   wr,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic                     ex_valid_i,
    input  logic [csr_pkg::XLEN-1:0] ex_cause_i,
    input  logic [csr_pkg::XLEN-1:0] ex_tval_i,
    output csr_pkg::priv_lvl_e       priv_lvl_o,
    output logic [csr_pkg::XLEN-1:0] mstatus_o,
    output logic [csr_pkg::XLEN-1:0] mepc_o,
    output logic [csr_pkg::XLEN-1:0] mcause_o,
    output logic [csr_pkg::XLEN-1:0] mtval_o,
    output logic [csr_pkg::XLEN-1:0] epc_o,
    output logic                     eret_o,
    output logic                     flush_o
);
    import csr_pkg::*;

    priv_lvl_e       priv_q, priv_n;
    priv_lvl_e       mpp_q, mpp_n;
    logic            mie_q, mie_n;
    logic            mpie_q, mpie_n;
    logic [XLEN-1:0] mepc_q, mepc_n;
    logic [XLEN-1:0] mcause_q, mcause_n;
    logic [XLEN-1:0] mtval_q, mtval_n;

    always_comb begin
        priv_n   = priv_q;
        mpp_n    = mpp_q;
        mie_n    = mie_q;
        mpie_n   = mpie_q;
        mepc_n   = mepc_q;
        mcause_n = mcause_q;
        mtval_n  = mtval_q;
        flush_o  = 1'b0;
        eret_o   = 1'b0;

        // ------------------------------------------------------------------
        // software writes
        // ------------------------------------------------------------------
        if (wr.we) begin
            case (csr_addr_e'(wr.addr))
                MSTATUS: begin
                    mie_n  = wr.wdata[MSTATUS_MIE_BIT];
                    mpie_n = wr.wdata[MSTATUS_MPIE_BIT];
                    // mpp is WARL, anything but M reads back as U
                    mpp_n  = (&wr.wdata[MSTATUS_MPP_LSB +: 2]) ? PRIV_M : PRIV_U;
                    // side effects on fetch, so flush the pipeline
                    flush_o = 1'b1;
                end
                MEPC:    mepc_n   = {wr.wdata[XLEN-1:1], 1'b0};
                MCAUSE:  mcause_n = wr.wdata;
                MTVAL:   mtval_n  = wr.wdata;
                default: ;
            endcase
        end

        // trap entry, always into M; wins over a simultaneous mret
        if (ex_valid_i) begin
            mcause_n = ex_cause_i;
            mepc_n   = {pc_i[XLEN-1:1], 1'b0};
            mtval_n  = ex_tval_i;
            mpie_n   = mie_q;
            mie_n    = 1'b0;
            mpp_n    = priv_q;
            priv_n   = PRIV_M;
        end else if (wr.mret) begin
            // restore enable and level, mpp drops to U
            mie_n  = mpie_q;
            mpie_n = 1'b1;
            priv_n = mpp_q;
            mpp_n  = PRIV_U;
            eret_o = 1'b1;
        end
    end

    // mstatus view, everything outside the three fields reads zero
    always_comb begin
        mstatus_o                             = '0;
        mstatus_o[MSTATUS_MIE_BIT]            = mie_q;
        mstatus_o[MSTATUS_MPIE_BIT]           = mpie_q;
        mstatus_o[MSTATUS_MPP_LSB +: 2]       = mpp_q;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            priv_q   <= PRIV_M;
            mpp_q    <= PRIV_U;
            mie_q    <= 1'b0;
            mpie_q   <= 1'b0;
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else begin
            priv_q   <= priv_n;
            mpp_q    <= mpp_n;
            mie_q    <= mie_n;
            mpie_q   <= mpie_n;
            mepc_q   <= mepc_n;
            mcause_q <= mcause_n;
            mtval_q  <= mtval_n;
        end
    end

    assign priv_lvl_o = priv_q;
    assign mepc_o     = mepc_q;
    assign mcause_o   = mcause_q;
    assign mtval_o    = mtval_q;
    // return target for mret
    assign epc_o      = mepc_q;

endmodule

//--- hdl/machine_regs.sv
// machine registers
// mtvec, mscratch, mie and mip with their WARL write masks; samples the
// external interrupt line and forms the trap vector base
module machine_regs (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [csr_pkg::XLEN-1:0] boot_addr_i,
    csr_wr_if.sink                   wr,
    input  logic                     irq_i,
    input  logic [csr_pkg::XLEN-1:0] ex_cause_i,
    output logic [csr_pkg::XLEN-1:0] mtvec_o,
    output logic [csr_pkg::XLEN-1:0] mscratch_o,
    output logic [csr_pkg::XLEN-1:0] mie_o,
    output logic [csr_pkg::XLEN-1:0] mip_o,
    output logic [csr_pkg::XLEN-1:0] trap_vector_base_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] mtvec_q, mtvec_n;
    logic [XLEN-1:0] mscratch_q, mscratch_n;
    logic [XLEN-1:0] mie_q, mie_n;
    logic [XLEN-1:0] mip_q, mip_n;

    always_comb begin
        mtvec_n    = mtvec_q;
        mscratch_n = mscratch_q;
        mie_n      = mie_q;
        mip_n      = mip_q;
        if (wr.we) begin
            case (csr_addr_e'(wr.addr))
                MTVEC: begin
                    mtvec_n = {wr.wdata[XLEN-1:2], 1'b0, wr.wdata[0]};
                    // vectored mode needs a 256 byte aligned base
                    if (wr.wdata[0]) begin
                        mtvec_n = {wr.wdata[XLEN-1:8], 7'b0, 1'b1};
                    end
                end
                MSCRATCH: mscratch_n = wr.wdata;
                MIE:      mie_n      = wr.wdata & MIE_MASK;
                MIP:      mip_n      = wr.wdata & MIP_WMASK;
                default: ;
            endcase
        end
        // meip mirrors the external line every cycle
        mip_n[IRQ_M_EXT] = irq_i;
    end

    // ------------------------------------------------------------------
    // trap vector, base + 4 * cause for vectored interrupts
    // ------------------------------------------------------------------
    always_comb begin
        trap_vector_base_o = {mtvec_q[XLEN-1:2], 2'b0};
        // the alignment lets the cause replace bits [7:2] without an adder
        if (mtvec_q[0] && |(ex_cause_i & INTERRUPT_FLAG)) begin
            trap_vector_base_o[7:2] = ex_cause_i[5:0];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            // boot in direct mode at the boot address
            mtvec_q    <= {boot_addr_i[XLEN-1:2], 2'b0};
            mscratch_q <= '0;
            mie_q      <= '0;
            mip_q      <= '0;
        end else begin
            mtvec_q    <= mtvec_n;
            mscratch_q <= mscratch_n;
            mie_q      <= mie_n;
            mip_q      <= mip_n;
        end
    end

    assign mtvec_o    = mtvec_q;
    assign mscratch_o = mscratch_q;
    assign mie_o      = mie_q;
    assign mip_o      = mip_q;

endmodule

//--- hdl/exception_arbiter.sv
// exception arbiter
// picks the highest priority enabled machine interrupt and merges it with
// illegal CSR accesses into one exception output
module exception_arbiter (
    input  csr_pkg::priv_lvl_e       priv_lvl_i,
    input  logic                     mstatus_mie_i,
    input  logic [csr_pkg::XLEN-1:0] mie_i,
    input  logic [csr_pkg::XLEN-1:0] mip_i,
    input  logic                     illegal_i,
    output logic                     ex_valid_o,
    output logic [csr_pkg::XLEN-1:0] ex_cause_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] pending;
    logic            global_en;

    assign pending = mie_i & mip_i;
    // always enabled below M, gated by mstatus.mie in M
    assign global_en = (priv_lvl_i == PRIV_U) || mstatus_mie_i;

    always_comb begin
        ex_valid_o = 1'b0;
        ex_cause_o = '0;
        // external first, then software, then timer
        if (pending[IRQ_M_EXT]) begin
            ex_cause_o = INTERRUPT_FLAG | XLEN'(IRQ_M_EXT);
        end else if (pending[IRQ_M_SW]) begin
            ex_cause_o = INTERRUPT_FLAG | XLEN'(IRQ_M_SW);
        end else if (pending[IRQ_M_TIMER]) begin
            ex_cause_o = INTERRUPT_FLAG | XLEN'(IRQ_M_TIMER);
        end
        ex_valid_o = global_en && (|pending);
        // illegal access overrides any interrupt
        if (illegal_i) begin
            ex_valid_o = 1'b1;
            ex_cause_o = CAUSE_ILLEGAL_INSTR;
        end
    end

endmodule

//--- hdl/perf_counters.sv
// performance counters
// free running cycle counter and retired instruction counter, both
// loadable through mcycle and minstret
module perf_counters (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    csr_wr_if.sink                   wr,
    input  logic                     commit_ack_i,
    output logic [csr_pkg::XLEN-1:0] cycle_o,
    output logic [csr_pkg::XLEN-1:0] instret_o
);
    import csr_pkg::*;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cycle_o   <= '0;
            instret_o <= '0;
        end else begin
            // a write replaces the increment for that cycle
            if (wr.we && wr.addr == MCYCLE) begin
                cycle_o <= wr.wdata;
            end else begin
                cycle_o <= cycle_o + 1'b1;
            end
            if (wr.we && wr.addr == MINSTRET) begin
                instret_o <= wr.wdata;
            end else if (commit_ack_i) begin
                instret_o <= instret_o + 1'b1;
            end
        end
    end

endmodule

//--- hdl/csr_regfile.sv
// machine-mode CSR file
// top level of the CSR block for a two-level (M/U) core: access control,
// read mux, trap state, machine registers, counters and interrupt arbiter
module csr_regfile (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [csr_pkg::XLEN-1:0] boot_addr_i,
    input  csr_pkg::csr_op_e         csr_op_i,
    input  logic [11:0]              csr_addr_i,
    input  logic [csr_pkg::XLEN-1:0] csr_wdata_i,
    input  logic [csr_pkg::XLEN-1:0] pc_i,
    input  logic                     ex_valid_i,
    input  logic [csr_pkg::XLEN-1:0] ex_cause_i,
    input  logic [csr_pkg::XLEN-1:0] ex_tval_i,
    input  logic                     commit_ack_i,
    input  logic                     irq_i,
    output logic [csr_pkg::XLEN-1:0] csr_rdata_o,
    output logic                     csr_ex_valid_o,
    output logic [csr_pkg::XLEN-1:0] csr_ex_cause_o,
    output logic [csr_pkg::XLEN-1:0] epc_o,
    output logic                     eret_o,
    output logic                     flush_o,
    output logic [csr_pkg::XLEN-1:0] trap_vector_base_o,
    output csr_pkg::priv_lvl_e       priv_lvl_o
);
    import csr_pkg::*;

    logic [XLEN-1:0] rdata, mstatus, mepc, mcause, mtval;
    logic [XLEN-1:0] mtvec, mscratch, mie, mip, cycle, instret;
    logic            hit;
    logic            illegal;

    // qualified write and return command
    csr_wr_if wr_if ();

    csr_access_ctrl i_access_ctrl (
        .csr_op_i, .csr_addr_i, .csr_wdata_i,
        .priv_lvl_i (priv_lvl_o),
        .rdata_i    (rdata),
        .hit_i      (hit),
        .csr_rdata_o,
        .illegal_o  (illegal),
        .wr         (wr_if.source)
    );

    csr_read_mux i_read_mux (
        .addr_i     (csr_addr_i),
        .mstatus_i  (mstatus),
        .mie_i      (mie),
        .mip_i      (mip),
        .mtvec_i    (mtvec),
        .mscratch_i (mscratch),
        .mepc_i     (mepc),
        .mcause_i   (mcause),
        .mtval_i    (mtval),
        .cycle_i    (cycle),
        .instret_i  (instret),
        .rdata_o    (rdata),
        .hit_o      (hit)
    );

    trap_ctrl i_trap_ctrl (
        .clk_i, .rst_ni,
        .wr         (wr_if.sink),
        .pc_i, .ex_valid_i, .ex_cause_i, .ex_tval_i,
        .priv_lvl_o,
        .mstatus_o  (mstatus),
        .mepc_o     (mepc),
        .mcause_o   (mcause),
        .mtval_o    (mtval),
        .epc_o, .eret_o, .flush_o
    );

    machine_regs i_machine_regs (
        .clk_i, .rst_ni, .boot_addr_i,
        .wr         (wr_if.sink),
        .irq_i,
        // vector is formed from the cause this block raises
        .ex_cause_i (csr_ex_cause_o),
        .mtvec_o    (mtvec),
        .mscratch_o (mscratch),
        .mie_o      (mie),
        .mip_o      (mip),
        .trap_vector_base_o
    );

    perf_counters i_perf_counters (
        .clk_i, .rst_ni,
        .wr         (wr_if.sink),
        .commit_ack_i,
        .cycle_o    (cycle),
        .instret_o  (instret)
    );

    exception_arbiter i_exception_arbiter (
        .priv_lvl_i    (priv_lvl_o),
        .mstatus_mie_i (mstatus[MSTATUS_MIE_BIT]),
        .mie_i         (mie),
        .mip_i         (mip),
        .illegal_i     (illegal),
        .ex_valid_o    (csr_ex_valid_o),
        .ex_cause_o    (csr_ex_cause_o)
    );

endmodule

//--- verif/csr_regfile_tb.sv
// testbench for the machine-mode CSR file
// directed interrupt, trap and access-check sequences followed by seeded random
// traffic, all checked cycle by cycle against a reference model
module csr_regfile_tb;
    import csr_pkg::*;

    localparam logic [63:0] BOOT_ADDR     = 64'h0000_0000_8000_0106;
    localparam int          RANDOM_CYCLES = 600;
    localparam int          WAIT_LIMIT    = 20;

    logic        clk_i, rst_ni, ex_valid_i, commit_ack_i, irq_i;
    logic [63:0] boot_addr_i, csr_wdata_i, pc_i, ex_cause_i, ex_tval_i;
    csr_op_e     csr_op_i;
    logic [11:0] csr_addr_i;
    logic [63:0] csr_rdata_o, csr_ex_cause_o, epc_o, trap_vector_base_o;
    logic        csr_ex_valid_o, eret_o, flush_o;
    priv_lvl_e   priv_lvl_o;
    integer      seed;

    // reference model state
    logic [1:0]  m_priv, m_mpp;
    logic        m_mie_b, m_mpie;
    logic [63:0] m_mepc, m_mcause, m_mtval, m_mtvec, m_mscratch;
    logic [63:0] m_mie, m_mip, m_cycle, m_instret;
    // outputs seen in the last checked cycle
    logic        samp_valid;
    logic [63:0] samp_cause, samp_vec, samp_rdata;

    csr_regfile i_csr_regfile (.*);

    always #4 clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_eq(input logic [63:0] exp_v, input logic [63:0] act_v,
                            input string what);
        if (exp_v !== act_v) begin
            $display("[ERROR] %0t: %s expected %h, got %h", $time, what, exp_v, act_v);
            report_failure("mismatch against the reference model");
        end
    endtask

    function automatic logic known_addr(input logic [11:0] a);
        return a == MSTATUS || a == MIE || a == MTVEC || a == MSCRATCH || a == MEPC ||
               a == MCAUSE || a == MTVAL || a == MIP || a == MCYCLE || a == MINSTRET ||
               a == CYCLE || a == INSTRET;
    endfunction

    function automatic logic [63:0] model_value(input logic [11:0] a);
        case (a)
            12'h300: return (64'(m_mie_b) << 3) | (64'(m_mpie) << 7) | (64'(m_mpp) << 11);
            12'h304: return m_mie;
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'h344: return m_mip;
            12'hB00, 12'hC00: return m_cycle;
            12'hB02, 12'hC02: return m_instret;
            default: return 64'h0;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // model next state, trap and mret work on the values before the edge
    // ----------------------------------------------------------------------
    task automatic update_model(input logic we, input logic [63:0] wd);
        logic       old_mie, old_mpie;
        logic [1:0] old_mpp, old_priv;
        old_mie  = m_mie_b;
        old_mpie = m_mpie;
        old_mpp  = m_mpp;
        old_priv = m_priv;
        m_cycle  = m_cycle + 1;
        if (commit_ack_i)
            m_instret = m_instret + 1;
        if (we) begin
            case (csr_addr_i)
                12'h300: begin
                    m_mie_b = wd[3];
                    m_mpie  = wd[7];
                    // mpp keeps M only when M is written
                    m_mpp   = (wd[12:11] == 2'b11) ? 2'b11 : 2'b00;
                end
                12'h304: m_mie = wd & 64'h888;
                12'h305: m_mtvec = wd[0] ? {wd[63:8], 8'h01} : (wd & ~64'h2);
                12'h340: m_mscratch = wd;
                12'h341: m_mepc = {wd[63:1], 1'b0};
                12'h342: m_mcause = wd;
                12'h343: m_mtval = wd;
                12'h344: m_mip = wd & 64'h088;
                12'hB00: m_cycle = wd;
                12'hB02: m_instret = wd;
                default: ;
            endcase
        end
        if (ex_valid_i) begin
            m_mcause = ex_cause_i;
            m_mepc   = {pc_i[63:1], 1'b0};
            m_mtval  = ex_tval_i;
            m_mpie   = old_mie;
            m_mie_b  = 1'b0;
            m_mpp    = old_priv;
            m_priv   = 2'b11;
        end else if (csr_op_i == CSR_MRET) begin
            m_mie_b = old_mpie;
            m_mpie  = 1'b1;
            m_priv  = old_mpp;
            m_mpp   = 2'b00;
        end
        // external line lands in mip one cycle later
        m_mip[11] = irq_i;
    endtask

    // check the current cycle mid-period, then step to the next drive point
    task automatic run_cycle();
        logic        access, write, illegal, we, exp_valid;
        logic [63:0] cur, wd, pend, exp_cause, exp_vec;
        #3;
        cur     = model_value(csr_addr_i);
        access  = csr_op_i == CSR_READ || csr_op_i == CSR_WRITE ||
                  csr_op_i == CSR_SET || csr_op_i == CSR_CLEAR;
        write   = access && csr_op_i != CSR_READ;
        illegal = access && (!known_addr(csr_addr_i) || csr_addr_i[9:8] > m_priv ||
                  (write && csr_addr_i[11:10] == 2'b11));
        we      = write && !illegal;
        case (csr_op_i)
            CSR_SET:   wd = csr_wdata_i | cur;
            CSR_CLEAR: wd = ~csr_wdata_i & cur;
            default:   wd = csr_wdata_i;
        endcase
        // priority external, software, timer
        pend      = m_mie & m_mip;
        exp_cause = 64'h0;
        if (pend[11])
            exp_cause = INTERRUPT_FLAG | 64'd11;
        else if (pend[3])
            exp_cause = INTERRUPT_FLAG | 64'd3;
        else if (pend[7])
            exp_cause = INTERRUPT_FLAG | 64'd7;
        exp_valid = (pend != 0) && (m_priv == 2'b00 || m_mie_b);
        if (illegal) begin
            exp_valid = 1'b1;
            exp_cause = 64'd2;
        end
        exp_vec = {m_mtvec[63:2], 2'b00};
        if (m_mtvec[0] && exp_cause[63])
            exp_vec[7:2] = exp_cause[5:0];
        check_eq((access && !illegal) ? cur : 64'h0, csr_rdata_o, "read data");
        check_eq(64'(exp_valid), 64'(csr_ex_valid_o), "exception valid");
        check_eq(exp_cause, csr_ex_cause_o, "exception cause");
        check_eq(m_mepc, epc_o, "epc");
        check_eq(64'(csr_op_i == CSR_MRET && !ex_valid_i), 64'(eret_o), "eret pulse");
        check_eq(64'(we && csr_addr_i == MSTATUS), 64'(flush_o), "flush pulse");
        check_eq(exp_vec, trap_vector_base_o, "trap vector base");
        check_eq(64'(m_priv), 64'(priv_lvl_o), "privilege level");
        samp_valid = csr_ex_valid_o;
        samp_cause = csr_ex_cause_o;
        samp_vec   = trap_vector_base_o;
        samp_rdata = csr_rdata_o;
        update_model(we, wd);
        @(posedge clk_i);
        #1;
    endtask

    task automatic drive(input csr_op_e op, input logic [11:0] addr, input logic [63:0] wdata);
        csr_op_i     = op;
        csr_addr_i   = addr;
        csr_wdata_i  = wdata;
        ex_valid_i   = 1'b0;
        commit_ack_i = 1'b0;
        run_cycle();
    endtask

    task automatic take_trap(input logic [63:0] pc, input logic [63:0] cause,
                             input logic [63:0] tval);
        csr_op_i   = CSR_NONE;
        ex_valid_i = 1'b1;
        pc_i       = pc;
        ex_cause_i = cause;
        ex_tval_i  = tval;
        run_cycle();
        ex_valid_i = 1'b0;
    endtask

    task automatic wait_for_cause(input logic [63:0] cause);
        int n;
        n = 0;
        while (!(samp_valid && samp_cause == cause)) begin
            if (n == WAIT_LIMIT)
                report_failure("timed out waiting for the expected interrupt cause");
            drive(CSR_NONE, 12'h0, 64'h0);
            n++;
        end
    endtask

    function automatic logic [11:0] addr_at(input logic [3:0] idx);
        case (idx)
            4'd0: return MSTATUS;
            4'd1: return MIE;
            4'd2: return MTVEC;
            4'd3: return MSCRATCH;
            4'd4: return MEPC;
            4'd5: return MCAUSE;
            4'd6: return MTVAL;
            4'd7: return MIP;
            4'd8: return MCYCLE;
            4'd9: return MINSTRET;
            4'd10: return CYCLE;
            4'd11: return INSTRET;
            default: return 12'($random(seed));
        endcase
    endfunction

    task automatic random_cycle();
        logic [31:0] r;
        r = $random(seed);
        if (r[3:0] < 4)
            csr_op_i = CSR_READ;
        else if (r[3:0] < 7)
            csr_op_i = CSR_WRITE;
        else if (r[3:0] < 9)
            csr_op_i = CSR_SET;
        else if (r[3:0] < 11)
            csr_op_i = CSR_CLEAR;
        else if (r[3:0] == 11)
            csr_op_i = CSR_MRET;
        else
            csr_op_i = CSR_NONE;
        csr_addr_i   = addr_at(r[11:8]);
        csr_wdata_i  = {$random(seed), $random(seed)};
        // never a trap together with mret
        ex_valid_i   = (r[7:4] == 4'd0) && csr_op_i != CSR_MRET;
        pc_i         = {$random(seed), $random(seed)};
        ex_cause_i   = {$random(seed), $random(seed)};
        ex_tval_i    = {$random(seed), $random(seed)};
        irq_i        = r[12] & r[13];
        commit_ack_i = r[14];
        run_cycle();
    endtask

    initial begin
        seed = 26842;
        clk_i = 1'b0;
        rst_ni = 1'b0;
        boot_addr_i = BOOT_ADDR;
        csr_op_i = CSR_NONE;
        csr_addr_i = 12'h0;
        csr_wdata_i = 64'h0;
        pc_i = 64'h0;
        ex_valid_i = 1'b0;
        ex_cause_i = 64'h0;
        ex_tval_i = 64'h0;
        commit_ack_i = 1'b0;
        irq_i = 1'b0;
        m_priv = 2'b11;
        {m_mpp, m_mie_b, m_mpie} = '0;
        {m_mepc, m_mcause, m_mtval, m_mscratch} = '0;
        {m_mie, m_mip, m_cycle, m_instret} = '0;
        m_mtvec = {BOOT_ADDR[63:2], 2'b00};
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // --------------------------------------------------------------------
        // interrupts, global enable and vectored base
        // --------------------------------------------------------------------
        drive(CSR_WRITE, MTVEC, 64'h1000_00f7);
        drive(CSR_WRITE, MIE, '1);
        drive(CSR_WRITE, MIP, '1);
        drive(CSR_WRITE, MSTATUS, 64'h8);
        check_eq(64'h0, 64'(samp_valid), "pending interrupt with mie clear");
        drive(CSR_NONE, 12'h0, 64'h0);
        check_eq(INTERRUPT_FLAG | 64'd3, samp_cause, "software before timer");
        check_eq(64'h1000_000c, samp_vec, "vectored base for msip");
        irq_i = 1'b1;
        wait_for_cause(INTERRUPT_FLAG | 64'd11);
        check_eq(64'h1000_002c, samp_vec, "vectored base for meip");
        // direct mode
        drive(CSR_WRITE, MTVEC, 64'h2000_0006);
        drive(CSR_CLEAR, MSTATUS, 64'h8);
        check_eq(64'h2000_0004, samp_vec, "direct base");
        drive(CSR_NONE, 12'h0, 64'h0);
        check_eq(64'h0, 64'(samp_valid), "interrupt masked in M");

        // drop to U, where interrupts are always taken
        drive(CSR_MRET, 12'h0, 64'h0);
        drive(CSR_NONE, 12'h0, 64'h0);
        check_eq(64'h1, 64'(samp_valid), "interrupt taken in U");
        drive(CSR_READ, MSCRATCH, 64'h0);
        check_eq(64'd2, samp_cause, "M register read from U");
        drive(CSR_WRITE, CYCLE, 64'h55);
        check_eq(64'd2, samp_cause, "write to read-only counter");
        take_trap(64'h0000_0000_8000_1235, 64'd5, 64'hdead);
        drive(CSR_READ, MEPC, 64'h0);
        check_eq(64'h0000_0000_8000_1234, samp_rdata, "mepc after trap");

        // counter load
        drive(CSR_WRITE, MCYCLE, 64'h100);
        drive(CSR_READ, CYCLE, 64'h0);
        check_eq(64'h100, samp_rdata, "cycle after load");
        irq_i = 1'b0;

        repeat (RANDOM_CYCLES) random_cycle();
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- csr_regfile.f
hdl/csr_pkg.sv
hdl/csr_wr_if.sv
hdl/csr_access_ctrl.sv
hdl/csr_read_mux.sv
hdl/trap_ctrl.sv
hdl/machine_regs.sv
hdl/exception_arbiter.sv
hdl/perf_counters.sv
hdl/csr_regfile.sv
verif/csr_regfile_tb.sv
